// File: Makefile
VERILATOR ?= verilator
TOP       ?= hazard_pipe_tb
FILELIST  ?= hazard_pipe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: data_mem.sv
// data memory with preload port
`timescale 1ns/1ns

module data_mem #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              we_i,
    input  logic [$clog2(DMEM_DEPTH)-1:0]     waddr_i,
    input  logic [hazard_pipe_pkg::XLEN-1:0]  wdata_i,
    input  logic [$clog2(DMEM_DEPTH)-1:0]     raddr_i,
    input  logic                              hold_i,
    output logic [hazard_pipe_pkg::XLEN-1:0]  rdata_o
);
    import hazard_pipe_pkg::*;

    logic [XLEN-1:0] mem [DMEM_DEPTH];

    // preload only, the pipe itself never stores
    always_ff @(posedge clk_i)
    begin
        if (we_i)
        begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read lines up with the token entering MEM1/MEM2
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            rdata_o <= '0;
        end
        else if (!hold_i)
        begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

// File: execute_unit.sv
// EX stage
`timescale 1ns/1ns

module execute_unit (
    input  logic                                     id_valid_i,
    input  hazard_pipe_pkg::opcode_e                 id_op_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   id_rd_i,
    input  logic [hazard_pipe_pkg::XLEN-1:0]         id_imm_i,
    input  logic                                     id_write_rd_i,
    input  logic [hazard_pipe_pkg::XLEN-1:0]         rf_rs1_data_i,
    input  logic [hazard_pipe_pkg::XLEN-1:0]         rf_rs2_data_i,
    input  hazard_pipe_pkg::fwd_sel_e                fwd_rs1_sel_i,
    input  hazard_pipe_pkg::fwd_sel_e                fwd_rs2_sel_i,
    stage_if.mon                                     ex_mem1,
    stage_if.mon                                     mem1_mem2,
    stage_if.mon                                     mem2_wb,
    stage_if.src                                     out,
    output logic                                     branch_taken_o
);
    import hazard_pipe_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            operands_equal;

    // operand muxes driven by the controller's priority decision
    function automatic logic [XLEN-1:0] pick_operand(input fwd_sel_e sel,
                                                     input logic [XLEN-1:0] rf_data);
        case (sel)
            FWD_EX_MEM1:   return ex_mem1.result;
            FWD_MEM1_MEM2: return mem1_mem2.result;
            // MEM2/WB already carries the loaded word
            FWD_MEM2_WB:   return mem2_wb.result;
            default:       return rf_data;
        endcase
    endfunction

    assign op_a = pick_operand(fwd_rs1_sel_i, rf_rs1_data_i);
    assign op_b = pick_operand(fwd_rs2_sel_i, rf_rs2_data_i);

    assign operands_equal = (op_a == op_b);

    always_comb
    begin
        case (id_op_i)
            OP_ADD:  result = op_a + op_b;
            OP_XOR:  result = op_a ^ op_b;
            // address for data_mem, read in MEM1
            OP_LOAD: result = op_a + id_imm_i;
            // compare outcome, nothing consumes it
            default: result = {{(XLEN-1){1'b0}}, operands_equal};
        endcase
    end

    // predicted not taken, so equality means a redirect
    assign branch_taken_o = id_valid_i && (id_op_i == OP_BRANCH) && operands_equal;

    // token into EX/MEM1
    assign out.valid    = id_valid_i;
    assign out.op       = id_op_i;
    assign out.rd       = id_rd_i;
    assign out.write_rd = id_write_rd_i;
    assign out.result   = result;

endmodule

// File: hazard_pipe.f
hazard_pipe_pkg.sv
stage_if.sv
issue_stage.sv
execute_unit.sv
pipe_stage.sv
data_mem.sv
register_file.sv
pipeline_controller.sv
hazard_pipe_top.sv
hazard_pipe_assert.sv
hazard_pipe_tb.sv

// File: hazard_pipe_assert.sv
// controller assertions
`timescale 1ns/1ns

module hazard_pipe_assert (
    input logic                      clk_i,
    input logic                      rstn_i,
    input logic                      redirect_i,
    input logic                      id_ex_stall_i,
    input logic                      ex_mem1_flush_i,
    input logic                      mem_stall_i,
    input hazard_pipe_pkg::fwd_sel_e fwd_rs1_sel_i,
    input hazard_pipe_pkg::fwd_sel_e fwd_rs2_sel_i,
    input logic                      ex_mem1_valid_i,
    input hazard_pipe_pkg::opcode_e  ex_mem1_op_i
);
    import hazard_pipe_pkg::*;

    // failures so far, summed into the testbench error count
    int fail_count = 0;

    // a branch only resolves when it leaves ID/EX
    redirect_not_stalled: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(redirect_i && id_ex_stall_i))
    else
    begin
        $error("redirect raised while ID/EX is stalled");
        fail_count++;
    end

    // a bubble under memory wait would drop the held EX/MEM1 token
    no_bubble_in_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(ex_mem1_flush_i && mem_stall_i))
    else
    begin
        $error("EX/MEM1 flushed during memory stall");
        fail_count++;
    end

    // EX/MEM1 of a load holds an address, not data
    no_load_forward: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(ex_mem1_valid_i && ex_mem1_op_i == OP_LOAD
          && (fwd_rs1_sel_i == FWD_EX_MEM1 || fwd_rs2_sel_i == FWD_EX_MEM1)))
    else
    begin
        $error("load forwarded from EX/MEM1");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> (!redirect_i && !id_ex_stall_i && !mem_stall_i))
    else
    begin
        $error("redirect or stall active right after reset");
        fail_count++;
    end

endmodule

// controller outputs as wired in the top level, which also has the clock
bind hazard_pipe_top hazard_pipe_assert i_hazard_pipe_assert (
    .clk_i,
    .rstn_i,
    .redirect_i(redirect_o),
    .id_ex_stall_i(id_ex_stall),
    .ex_mem1_flush_i(ex_mem1_flush),
    .mem_stall_i(mem_stall),
    .fwd_rs1_sel_i(fwd_rs1_sel),
    .fwd_rs2_sel_i(fwd_rs2_sel),
    .ex_mem1_valid_i(st[1].valid),
    .ex_mem1_op_i(st[1].op)
);

// File: hazard_pipe_pkg.sv
// hazard pipe shared definitions
package hazard_pipe_pkg;

    // datapath and register address widths
    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // stage registers after EX: EX/MEM1, MEM1/MEM2, MEM2/WB
    localparam int NUM_MEM_STAGES = 3;

    // the four supported operations
    typedef enum logic [1:0] {
        OP_ADD    = 2'd0,
        OP_XOR    = 2'd1,
        OP_LOAD   = 2'd2,
        OP_BRANCH = 2'd3
    } opcode_e;

    // operand source for EX, register file when nothing newer is in flight
    typedef enum logic [1:0] {
        FWD_RF        = 2'd0,
        FWD_MEM2_WB   = 2'd1,
        FWD_MEM1_MEM2 = 2'd2,
        FWD_EX_MEM1   = 2'd3
    } fwd_sel_e;

endpackage

// File: hazard_pipe_tb.sv
// hazard pipe testbench
`timescale 1ns/1ns

module hazard_pipe_tb;
    import hazard_pipe_pkg::*;

    localparam int DMEM_DEPTH = 16;
    localparam int AW = $clog2(DMEM_DEPTH);
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_INSTR = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + DMEM_DEPTH + 100;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  instr_valid_i;
    opcode_e               instr_op_i;
    logic [REG_ADDR_W-1:0] instr_rd_i;
    logic [REG_ADDR_W-1:0] instr_rs1_i;
    logic [REG_ADDR_W-1:0] instr_rs2_i;
    logic [XLEN-1:0]       instr_imm_i;
    logic                  instr_ready_o;
    logic                  lsu_stall_i;
    logic                  dmem_we_i;
    logic [AW-1:0]         dmem_addr_i;
    logic [XLEN-1:0]       dmem_wdata_i;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;
    logic                  redirect_o;

    logic [15:0] lfsr;

    // in-order model state
    logic [XLEN-1:0]       model_regs [32];
    logic [XLEN-1:0]       model_mem [DMEM_DEPTH];
    logic [REG_ADDR_W-1:0] exp_rd [$];
    logic [XLEN-1:0]       exp_data [$];
    opcode_e               exp_op [$];
    logic                  skip_next;

    int checks = 0;
    int errors = 0;
    int cycles = 0;
    int accepted = 0;
    int pushed = 0;
    int retired = 0;
    int squashed = 0;
    int taken = 0;
    int seen_redirects = 0;

    hazard_pipe_top #(.DMEM_DEPTH(DMEM_DEPTH)) i_hazard_pipe_top (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, shifting right
    function automatic logic [15:0] galois_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ 16'hB400;
        return next;
    endfunction

    // one step per bit taken, lsb out first
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
        return bits;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("** Error: %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("check failed: %s", what);
        end
    endtask

    // registers x0..x7 only, so dependences are dense
    task automatic drive_random_instr();
        logic [31:0] bits;
        bits = random_bits(2);
        instr_op_i = opcode_e'(bits[1:0]);
        bits = random_bits(3);
        instr_rd_i = {2'b00, bits[2:0]};
        bits = random_bits(3);
        instr_rs1_i = {2'b00, bits[2:0]};
        bits = random_bits(3);
        instr_rs2_i = {2'b00, bits[2:0]};
        bits = random_bits(8);
        instr_imm_i = {24'd0, bits[7:0]};
        // memory wait about one cycle in four
        bits = random_bits(2);
        lsu_stall_i = (bits[1:0] == 2'b00);
    endtask

    // execute the instruction on the ports in program order
    task automatic model_accept();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] value;
        if (skip_next)
        begin
            // wrong-path slot behind a taken branch
            skip_next = 1'b0;
            squashed++;
            return;
        end
        a = model_regs[instr_rs1_i];
        b = model_regs[instr_rs2_i];
        value = '0;
        case (instr_op_i)
            OP_ADD:  value = a + b;
            OP_XOR:  value = a ^ b;
            OP_LOAD:
            begin
                addr = a + instr_imm_i;
                value = model_mem[addr[AW-1:0]];
            end
            default:
            begin
                // not-taken prediction, equal operands redirect
                skip_next = (a == b);
                if (a == b)
                    taken++;
            end
        endcase
        if (instr_op_i != OP_BRANCH && instr_rd_i != '0)
        begin
            model_regs[instr_rd_i] = value;
            exp_rd.push_back(instr_rd_i);
            exp_data.push_back(value);
            exp_op.push_back(instr_op_i);
            pushed++;
        end
    endtask

    // outputs are settled a quarter period after the falling edge
    task automatic observe_outputs();
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        opcode_e               op;
        if (lsu_stall_i)
            check_true(!instr_ready_o && !wb_valid_o, "ready or retire while lsu_stall_i high");
        if (redirect_o)
            seen_redirects++;
        if (wb_valid_o)
        begin
            retired++;
            check_true(wb_rd_o != '0, "write to x0 retired");
            check_true(exp_rd.size() != 0, "retirement with nothing left in the model");
            if (exp_rd.size() != 0)
            begin
                rd = exp_rd.pop_front();
                data = exp_data.pop_front();
                op = exp_op.pop_front();
                check_value($sformatf("%s rd", op.name()), 32'(rd), 32'(wb_rd_o));
                check_value($sformatf("%s x%0d data", op.name(), rd), data, wb_data_o);
            end
        end
    endtask

    always @(posedge clk_i)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] bits;
        rstn_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_op_i = OP_ADD;
        instr_rd_i = '0;
        instr_rs1_i = '0;
        instr_rs2_i = '0;
        instr_imm_i = '0;
        lsu_stall_i = 1'b0;
        dmem_we_i = 1'b0;
        dmem_addr_i = '0;
        dmem_wdata_i = '0;
        lfsr = 16'd68;
        skip_next = 1'b0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;

        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;
        #(CLK_PERIOD / 4);
        check_true(!wb_valid_o && !redirect_o && instr_ready_o, "outputs not idle after reset");
        @(negedge clk_i);

        // preload every word, model keeps a copy
        for (int i = 0; i < DMEM_DEPTH; i++)
        begin
            bits = random_bits(32);
            dmem_we_i = 1'b1;
            dmem_addr_i = i[AW-1:0];
            dmem_wdata_i = bits;
            model_mem[i] = bits;
            @(negedge clk_i);
        end
        dmem_we_i = 1'b0;

        // random program, valid held high
        instr_valid_i = 1'b1;
        while (accepted < NUM_INSTR)
        begin
            drive_random_instr();
            #(CLK_PERIOD / 4);
            observe_outputs();
            // ready seen here means the next rising edge takes it
            if (instr_ready_o)
            begin
                model_accept();
                accepted++;
            end
            @(negedge clk_i);
        end

        // drain, still with memory waits
        instr_valid_i = 1'b0;
        while (retired < pushed)
        begin
            bits = random_bits(2);
            lsu_stall_i = (bits[1:0] == 2'b00);
            #(CLK_PERIOD / 4);
            observe_outputs();
            @(negedge clk_i);
        end
        lsu_stall_i = 1'b0;
        // catch late branches and stray retirements
        repeat (8)
        begin
            #(CLK_PERIOD / 4);
            observe_outputs();
            @(negedge clk_i);
        end

        check_value("retire count", pushed, retired);
        check_value("model queue left", 0, exp_rd.size());
        check_value("taken branches", taken, seen_redirects);
        errors += i_hazard_pipe_top.i_hazard_pipe_assert.fail_count;

        $display("checks %0d, errors %0d, retired %0d, squashed %0d, redirects %0d",
                 checks, errors, retired, squashed, seen_redirects);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: hazard_pipe_top.sv
// hazard pipe top level
`timescale 1ns/1ns

module hazard_pipe_top #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    input  logic                                     instr_valid_i,
    input  hazard_pipe_pkg::opcode_e                 instr_op_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   instr_rd_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   instr_rs1_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   instr_rs2_i,
    input  logic [hazard_pipe_pkg::XLEN-1:0]         instr_imm_i,
    output logic                                     instr_ready_o,
    input  logic                                     lsu_stall_i,
    input  logic                                     dmem_we_i,
    input  logic [$clog2(DMEM_DEPTH)-1:0]            dmem_addr_i,
    input  logic [hazard_pipe_pkg::XLEN-1:0]         dmem_wdata_i,
    output logic                                     wb_valid_o,
    output logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   wb_rd_o,
    output logic [hazard_pipe_pkg::XLEN-1:0]         wb_data_o,
    output logic                                     redirect_o
);
    import hazard_pipe_pkg::*;

    localparam int LAST = NUM_MEM_STAGES;

    logic                  id_valid;
    opcode_e               id_op;
    logic [REG_ADDR_W-1:0] id_rd;
    logic [REG_ADDR_W-1:0] id_rs1;
    logic [REG_ADDR_W-1:0] id_rs2;
    logic [XLEN-1:0]       id_imm;
    logic                  id_write_rd;
    logic [XLEN-1:0]       rf_rs1_data;
    logic [XLEN-1:0]       rf_rs2_data;
    logic [XLEN-1:0]       dmem_rdata;
    fwd_sel_e              fwd_rs1_sel;
    fwd_sel_e              fwd_rs2_sel;
    logic                  branch_taken;
    logic                  id_ex_stall;
    logic                  id_ex_flush;
    logic                  ex_mem1_flush;
    logic                  mem_stall;

    // 0 is the EX output, 1..3 are EX/MEM1, MEM1/MEM2, MEM2/WB
    stage_if st [NUM_MEM_STAGES+1] ();

    issue_stage i_issue_stage (
        .clk_i, .rstn_i, .instr_valid_i, .instr_op_i, .instr_rd_i,
        .instr_rs1_i, .instr_rs2_i, .instr_imm_i,
        .stall_i(id_ex_stall), .flush_i(id_ex_flush),
        .id_valid_o(id_valid), .id_op_o(id_op), .id_rd_o(id_rd), .id_rs1_o(id_rs1),
        .id_rs2_o(id_rs2), .id_imm_o(id_imm), .id_write_rd_o(id_write_rd)
    );

    execute_unit i_execute_unit (
        .id_valid_i(id_valid), .id_op_i(id_op), .id_rd_i(id_rd), .id_imm_i(id_imm),
        .id_write_rd_i(id_write_rd), .rf_rs1_data_i(rf_rs1_data), .rf_rs2_data_i(rf_rs2_data),
        .fwd_rs1_sel_i(fwd_rs1_sel), .fwd_rs2_sel_i(fwd_rs2_sel),
        .ex_mem1(st[1]), .mem1_mem2(st[2]), .mem2_wb(st[3]), .out(st[0]),
        .branch_taken_o(branch_taken)
    );

    // only EX/MEM1 ever takes a bubble, only MEM2/WB merges load data
    for (genvar k = 0; k < NUM_MEM_STAGES; k++)
    begin : g_stage
        pipe_stage #(.MERGE_LOAD(k == NUM_MEM_STAGES - 1)) i_pipe_stage (
            .clk_i, .rstn_i, .stall_i(mem_stall),
            .flush_i((k == 0) ? ex_mem1_flush : 1'b0),
            .load_data_i(dmem_rdata), .up(st[k]), .down(st[k+1])
        );
    end

    // address taken from EX/MEM1 as it moves into MEM1/MEM2
    data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) i_data_mem (
        .clk_i, .rstn_i, .we_i(dmem_we_i), .waddr_i(dmem_addr_i), .wdata_i(dmem_wdata_i),
        .raddr_i(st[1].result[$clog2(DMEM_DEPTH)-1:0]), .hold_i(mem_stall),
        .rdata_o(dmem_rdata)
    );

    register_file i_register_file (
        .clk_i, .rstn_i, .wb(st[LAST]), .wb_stall_i(mem_stall),
        .rs1_addr_i(id_rs1), .rs2_addr_i(id_rs2),
        .rs1_data_o(rf_rs1_data), .rs2_data_o(rf_rs2_data)
    );

    pipeline_controller i_pipeline_controller (
        .id_valid_i(id_valid), .id_rs1_i(id_rs1), .id_rs2_i(id_rs2),
        .ex_mem1(st[1]), .mem1_mem2(st[2]), .mem2_wb(st[3]),
        .branch_taken_i(branch_taken), .lsu_stall_i,
        .fwd_rs1_sel_o(fwd_rs1_sel), .fwd_rs2_sel_o(fwd_rs2_sel),
        .id_ex_stall_o(id_ex_stall), .id_ex_flush_o(id_ex_flush),
        .ex_mem1_flush_o(ex_mem1_flush), .mem_stall_o(mem_stall), .redirect_o
    );

    assign instr_ready_o = !id_ex_stall;

    // same condition as the register file write
    assign wb_valid_o = st[LAST].valid && st[LAST].write_rd && (st[LAST].rd != '0)
                        && !mem_stall;
    assign wb_rd_o    = st[LAST].rd;
    assign wb_data_o  = st[LAST].result;

endmodule

// File: issue_stage.sv
// ID/EX stage register
`timescale 1ns/1ns

module issue_stage (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    input  logic                                     instr_valid_i,
    input  hazard_pipe_pkg::opcode_e                 instr_op_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   instr_rd_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   instr_rs1_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   instr_rs2_i,
    input  logic [hazard_pipe_pkg::XLEN-1:0]         instr_imm_i,
    input  logic                                     stall_i,
    input  logic                                     flush_i,
    output logic                                     id_valid_o,
    output hazard_pipe_pkg::opcode_e                 id_op_o,
    output logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   id_rd_o,
    output logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   id_rs1_o,
    output logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   id_rs2_o,
    output logic [hazard_pipe_pkg::XLEN-1:0]         id_imm_o,
    output logic                                     id_write_rd_o
);
    import hazard_pipe_pkg::*;

    logic valid_q;

    // valid is the only control bit here
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            valid_q <= 1'b0;
        end
        else if (!stall_i)
        begin
            // on a redirect the instruction accepted this edge is wrong path
            valid_q <= instr_valid_i && !flush_i;
        end
    end

    // hold the whole entry while stalled
    always_ff @(posedge clk_i)
    begin
        if (!stall_i)
        begin
            id_op_o  <= instr_op_i;
            id_rd_o  <= instr_rd_i;
            id_rs1_o <= instr_rs1_i;
            id_rs2_o <= instr_rs2_i;
            id_imm_o <= instr_imm_i;
            // branches never write a register
            id_write_rd_o <= (instr_op_i != OP_BRANCH);
        end
    end

    assign id_valid_o = valid_q;

endmodule

// File: pipe_stage.sv
// post-EX stage register
`timescale 1ns/1ns

module pipe_stage #(
    parameter bit MERGE_LOAD = 1'b0
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              stall_i,
    input  logic                              flush_i,
    input  logic [hazard_pipe_pkg::XLEN-1:0]  load_data_i,
    stage_if.snk                              up,
    stage_if.src                              down
);
    import hazard_pipe_pkg::*;

    logic                  valid_q;
    opcode_e               op_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  write_rd_q;
    logic [XLEN-1:0]       result_q;

    // stall wins over flush, the held token must survive
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            valid_q <= 1'b0;
        end
        else if (!stall_i)
        begin
            valid_q <= up.valid && !flush_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_i)
        begin
            op_q       <= up.op;
            rd_q       <= up.rd;
            write_rd_q <= up.write_rd;
            // last stage swaps the address for the loaded word
            result_q   <= (MERGE_LOAD && up.op == OP_LOAD) ? load_data_i : up.result;
        end
    end

    assign down.valid    = valid_q;
    assign down.op       = op_q;
    assign down.rd       = rd_q;
    assign down.write_rd = write_rd_q;
    assign down.result   = result_q;

endmodule

// File: pipeline_controller.sv
// forwarding and hazard control
`timescale 1ns/1ns

module pipeline_controller (
    input  logic                                     id_valid_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   id_rs1_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   id_rs2_i,
    stage_if.mon                                     ex_mem1,
    stage_if.mon                                     mem1_mem2,
    stage_if.mon                                     mem2_wb,
    input  logic                                     branch_taken_i,
    input  logic                                     lsu_stall_i,
    output hazard_pipe_pkg::fwd_sel_e                fwd_rs1_sel_o,
    output hazard_pipe_pkg::fwd_sel_e                fwd_rs2_sel_o,
    output logic                                     id_ex_stall_o,
    output logic                                     id_ex_flush_o,
    output logic                                     ex_mem1_flush_o,
    output logic                                     mem_stall_o,
    output logic                                     redirect_o
);
    import hazard_pipe_pkg::*;

    logic ex_mem1_fwd_ok;
    logic mem1_mem2_fwd_ok;
    logic mem2_wb_fwd_ok;
    logic ex_mem1_load;
    logic mem1_mem2_load;
    logic load_use;

    // a load's result in EX/MEM1 and MEM1/MEM2 is only an address
    assign ex_mem1_fwd_ok = ex_mem1.valid && ex_mem1.write_rd && (ex_mem1.rd != '0)
                            && (ex_mem1.op != OP_LOAD);
    assign mem1_mem2_fwd_ok = mem1_mem2.valid && mem1_mem2.write_rd && (mem1_mem2.rd != '0)
                              && (mem1_mem2.op != OP_LOAD);
    // loaded word is merged by now
    assign mem2_wb_fwd_ok = mem2_wb.valid && mem2_wb.write_rd && (mem2_wb.rd != '0);

    // youngest producer wins when several write the same rd
    function automatic fwd_sel_e pick_source(input logic [REG_ADDR_W-1:0] rs);
        if (ex_mem1_fwd_ok && ex_mem1.rd == rs)
            return FWD_EX_MEM1;
        else if (mem1_mem2_fwd_ok && mem1_mem2.rd == rs)
            return FWD_MEM1_MEM2;
        else if (mem2_wb_fwd_ok && mem2_wb.rd == rs)
            return FWD_MEM2_WB;
        else
            return FWD_RF;
    endfunction

    assign fwd_rs1_sel_o = pick_source(id_rs1_i);
    assign fwd_rs2_sel_o = pick_source(id_rs2_i);

    // loads still waiting on data_mem
    assign ex_mem1_load = ex_mem1.valid && (ex_mem1.op == OP_LOAD) && (ex_mem1.rd != '0);
    assign mem1_mem2_load = mem1_mem2.valid && (mem1_mem2.op == OP_LOAD)
                            && (mem1_mem2.rd != '0);

    // load in MEM1 costs two bubbles, load in MEM2 one,
    // unless a younger non-load in EX/MEM1 shadows it
    assign load_use = id_valid_i && (
        (ex_mem1_load && (ex_mem1.rd == id_rs1_i || ex_mem1.rd == id_rs2_i)) ||
        (mem1_mem2_load && mem1_mem2.rd == id_rs1_i && fwd_rs1_sel_o != FWD_EX_MEM1) ||
        (mem1_mem2_load && mem1_mem2.rd == id_rs2_i && fwd_rs2_sel_o != FWD_EX_MEM1));

    // memory wait freezes everything behind EX
    assign mem_stall_o = lsu_stall_i;

    // the use waits in ID/EX while a bubble goes down the pipe
    assign id_ex_stall_o = load_use || mem_stall_o;
    // no bubble while the stages hold, that would drop the EX/MEM1 token
    assign ex_mem1_flush_o = load_use && !mem_stall_o;

    // branch only resolves when it actually leaves ID/EX
    assign redirect_o = branch_taken_i && !id_ex_stall_o;
    // squash the not-taken-path instruction arriving this edge
    assign id_ex_flush_o = redirect_o;

endmodule

// File: register_file.sv
// architectural register file
`timescale 1ns/1ns

module register_file (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    stage_if.mon                                     wb,
    input  logic                                     wb_stall_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   rs1_addr_i,
    input  logic [hazard_pipe_pkg::REG_ADDR_W-1:0]   rs2_addr_i,
    output logic [hazard_pipe_pkg::XLEN-1:0]         rs1_data_o,
    output logic [hazard_pipe_pkg::XLEN-1:0]         rs2_data_o
);
    import hazard_pipe_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_en;

    // retire once, on the edge the MEM2/WB token leaves
    assign wr_en = wb.valid && wb.write_rd && (wb.rd != '0) && !wb_stall_i;

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wb.rd] <= wb.result;
        end
    end

    // x0 hardwired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: stage_if.sv
// instruction token between stages
`timescale 1ns/1ns

interface stage_if;
    import hazard_pipe_pkg::*;

    // token fields
    logic                  valid;
    opcode_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic                  write_rd;
    // alu result, load address, or loaded word after MEM2/WB
    logic [XLEN-1:0]       result;

    // writer side
    modport src (output valid, output op, output rd, output write_rd, output result);

    // next stage register
    modport snk (input valid, input op, input rd, input write_rd, input result);

    // forwarding, hazard checks and writeback only look
    modport mon (input valid, input op, input rd, input write_rd, input result);

endinterface
